// File: hps_io_pkg.sv
////////////////////////////////////////////////////////////////////////////
// host I/O shared definitions
// command opcodes, window FSM states and word types
////////////////////////////////////////////////////////////////////////////

package hps_io_pkg;

	// host data word
	localparam int IO_W     = 16;
	// scan dimension
	localparam int TIMING_W = 12;
	// audio sample
	localparam int AUDIO_W  = 16;
	// attenuation field, msb mutes
	localparam int ATT_W    = 5;

	typedef logic [IO_W-1:0]     io_word_t;
	typedef logic [TIMING_W-1:0] timing_t;
	typedef logic [AUDIO_W-1:0]  sample_t;
	typedef logic [7:0]          aspect_t;
	typedef logic [1:0]          mix_t;

	// host command opcodes, first word after select rises
	typedef enum logic [7:0] {
		CMD_NONE    = 8'h00,
		CMD_CFG     = 8'h01,
		CMD_TIMING  = 8'h20,
		CMD_LED     = 8'h25,
		CMD_VOL     = 8'h26,
		CMD_VSET    = 8'h27,
		CMD_VS_WAIT = 8'h30
	} hps_cmd_e;

	// window calculator steps
	typedef enum logic [2:0] {
		WIN_IDLE,
		WIN_DIV,
		WIN_CLAMP,
		WIN_PLACE
	} win_state_e;

endpackage

// File: hps_cmd_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// host command controller
// decodes the strobe/ack command stream into config registers,
// holds off the ack for a vsync wait and muxes the board LEDs
////////////////////////////////////////////////////////////////////////////

module hps_cmd_ctrl (
	input  logic                         clk,
	input  logic                         resetd,
	input  logic                         i_io_sel,
	input  logic                         i_io_clk,
	input  hps_io_pkg::io_word_t         i_io_din,
	input  logic                         i_vs,
	input  logic                         i_led_user,
	input  logic [1:0]                   i_led_power,
	input  logic [1:0]                   i_led_disk,
	output logic                         o_io_ack,
	output hps_io_pkg::timing_t          o_width,
	output hps_io_pkg::timing_t          o_height,
	output hps_io_pkg::timing_t          o_vset,
	output logic [hps_io_pkg::ATT_W-1:0] o_vol_att,
	output logic                         o_csync_en,
	output logic [7:0]                   o_led
);
	import hps_io_pkg::*;

	logic       io_clk_d;
	logic       strobe;
	logic       strobe_q;
	logic       sel_q;
	io_word_t   din_q;
	logic       rack;
	logic       ack_hold;
	logic       has_cmd;
	hps_cmd_e   cmd;
	logic [3:0] cnt;
	logic       vs_d;
	logic       vs_rise;
	logic       vs_arm;
	logic       vs_wait;
	logic [7:0] led_mask;
	logic [7:0] led_state;
	logic       led_p;
	logic       led_d;
	logic       led_u;

	///////////////////////////  host strobe  ////////////////////////////////

	assign strobe  = i_io_clk & ~io_clk_d;
	assign vs_rise = i_vs & ~vs_d;

	// the word right after a wait opcode must not see its ack rise
	assign ack_hold = (vs_wait | (vs_arm & strobe & i_io_sel)) & ~vs_rise;

	always_ff @(posedge clk) begin
		if (resetd) begin
			io_clk_d <= 1'b0;
			strobe_q <= 1'b0;
			sel_q    <= 1'b0;
			vs_d     <= 1'b0;
			rack     <= 1'b0;
			o_io_ack <= 1'b0;
		end else begin
			io_clk_d <= i_io_clk;
			strobe_q <= strobe;
			sel_q    <= i_io_sel;
			vs_d     <= i_vs;
			if (!ack_hold)
				rack <= i_io_clk;
			o_io_ack <= rack;
		end
	end

	always_ff @(posedge clk) begin
		din_q <= i_io_din;
	end

	/////////////////////////  command decode  ///////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			has_cmd    <= 1'b0;
			cmd        <= CMD_NONE;
			cnt        <= '0;
			vs_arm     <= 1'b0;
			vs_wait    <= 1'b0;
			o_width    <= timing_t'(1920);
			o_height   <= timing_t'(1080);
			o_vset     <= '0;
			o_vol_att  <= '0;
			o_csync_en <= 1'b0;
			led_mask   <= '0;
			led_state  <= '0;
		end else begin
			if (!sel_q) begin
				has_cmd <= 1'b0;
				cmd     <= CMD_NONE;
			end else if (strobe_q) begin
				if (!has_cmd) begin
					// first word is the opcode
					has_cmd <= 1'b1;
					cmd     <= hps_cmd_e'(din_q[7:0]);
					cnt     <= '0;
					if (din_q[7:0] == CMD_VS_WAIT)
						vs_arm <= 1'b1;
				end else begin
					if (cnt != '1)
						cnt <= cnt + 4'd1;
					case (cmd)
						CMD_CFG:  o_csync_en <= din_q[3];
						CMD_TIMING: begin
							// words 1-3 and 5-7 carry porch and sync timing that nothing here uses
							if (cnt == 4'd0)
								o_width <= din_q[TIMING_W-1:0];
							if (cnt == 4'd4)
								o_height <= din_q[TIMING_W-1:0];
						end
						CMD_LED:  {led_mask, led_state} <= din_q;
						CMD_VOL:  o_vol_att <= din_q[ATT_W-1:0];
						CMD_VSET: o_vset <= din_q[TIMING_W-1:0];
						default:  ;
					endcase
				end
			end

			// released by the first vsync edge after the opcode
			if (vs_rise) begin
				vs_arm  <= 1'b0;
				vs_wait <= 1'b0;
			end else if (ack_hold) begin
				vs_wait <= 1'b1;
			end
		end
	end

	///////////////////////////  board LEDs  /////////////////////////////////

	assign led_p = ~i_led_power[1] | i_led_power[0];
	assign led_d = i_led_disk[0];
	assign led_u = i_led_user;

	assign o_led = (led_mask & led_state) |
		(~led_mask & {3'b000, led_p, 1'b0, led_d, 1'b0, led_u});

	// ack stays put until vsync lets the pending word through
	ack_freeze: assert property (@(posedge clk) disable iff (resetd)
		vs_wait && !vs_rise |=> $stable(o_io_ack));

endmodule

// File: video_window.sv
////////////////////////////////////////////////////////////////////////////
// aspect-ratio window calculator
// fits the core aspect ratio into the output frame and centres it
////////////////////////////////////////////////////////////////////////////

module video_window (
	input  logic                clk,
	input  logic                resetd,
	input  hps_io_pkg::timing_t i_width,
	input  hps_io_pkg::timing_t i_height,
	input  hps_io_pkg::timing_t i_vset,
	input  hps_io_pkg::aspect_t i_arx,
	input  hps_io_pkg::aspect_t i_ary,
	output hps_io_pkg::timing_t o_hmin,
	output hps_io_pkg::timing_t o_hmax,
	output hps_io_pkg::timing_t o_vmin,
	output hps_io_pkg::timing_t o_vmax
);
	import hps_io_pkg::*;

	localparam int PROD_W = TIMING_W + $bits(aspect_t);

	win_state_e        state;
	logic [2:0]        div_cnt;
	timing_t           width_s;
	timing_t           height_s;
	timing_t           vset_s;
	aspect_t           arx_s;
	aspect_t           ary_s;
	logic [PROD_W-1:0] prod_w;
	logic [PROD_W-1:0] prod_h;
	logic [PROD_W-1:0] wcalc;
	logic [PROD_W-1:0] hcalc;
	timing_t           video_w;
	timing_t           video_h;
	timing_t           hspare;
	timing_t           vspare;

	assign hspare = width_s - video_w;
	assign vspare = height_s - video_h;

	// fsm and window outputs, 8 cycles per pass
	always_ff @(posedge clk) begin
		if (resetd) begin
			state   <= WIN_IDLE;
			div_cnt <= '0;
			o_hmin  <= '0;
			o_hmax  <= '0;
			o_vmin  <= '0;
			o_vmax  <= '0;
		end else begin
			case (state)
				WIN_IDLE: begin
					div_cnt <= '0;
					if (i_arx != '0 && i_ary != '0) begin
						state <= WIN_DIV;
					end else begin
						// no aspect given, show the whole frame
						o_hmin <= '0;
						o_hmax <= i_width - timing_t'(1);
						o_vmin <= '0;
						o_vmax <= i_height - timing_t'(1);
					end
				end
				WIN_DIV: begin
					div_cnt <= div_cnt + 3'd1;
					if (div_cnt == 3'd4)
						state <= WIN_CLAMP;
				end
				WIN_CLAMP: state <= WIN_PLACE;
				WIN_PLACE: begin
					o_hmin <= hspare >> 1;
					o_hmax <= (hspare >> 1) + video_w - timing_t'(1);
					o_vmin <= vspare >> 1;
					o_vmax <= (vspare >> 1) + video_h - timing_t'(1);
					state  <= WIN_IDLE;
				end
				default: state <= WIN_IDLE;
			endcase
		end
	end

	// snapshot, products, quotients and clamped sizes
	always_ff @(posedge clk) begin
		if (state == WIN_IDLE) begin
			width_s  <= i_width;
			height_s <= i_height;
			vset_s   <= i_vset;
			arx_s    <= i_arx;
			ary_s    <= i_ary;
			prod_w   <= PROD_W'((i_vset != '0) ? i_vset : i_height) * PROD_W'(i_arx);
			prod_h   <= PROD_W'(i_width) * PROD_W'(i_ary);
		end
		if (state == WIN_DIV) begin
			wcalc <= prod_w / PROD_W'(ary_s);
			hcalc <= prod_h / PROD_W'(arx_s);
		end
		if (state == WIN_CLAMP) begin
			// fixed vset sets the height and lets the width run over
			video_w <= (vset_s == '0 && wcalc > PROD_W'(width_s)) ? width_s :
				wcalc[TIMING_W-1:0];
			video_h <= (vset_s != '0) ? vset_s :
				(hcalc > PROD_W'(height_s)) ? height_s : hcalc[TIMING_W-1:0];
		end
	end

	win_order: assert property (@(posedge clk) disable iff (resetd)
		(state == WIN_IDLE && i_width != '0) |-> o_hmin <= o_hmax);

endmodule

// File: audio_mixer.sv
////////////////////////////////////////////////////////////////////////////
// audio mixer, one channel
// deglitch, cross-feed with the other channel, attenuate and clamp
////////////////////////////////////////////////////////////////////////////

module audio_mixer (
	input  logic                         clk,
	input  logic                         resetd,
	input  logic [hps_io_pkg::ATT_W-1:0] i_att,
	input  hps_io_pkg::mix_t             i_mix,
	input  logic                         i_is_signed,
	input  hps_io_pkg::sample_t          i_sample,
	input  hps_io_pkg::sample_t          i_pre,
	output hps_io_pkg::sample_t          o_pre,
	output hps_io_pkg::sample_t          o_sample
);
	import hps_io_pkg::*;

	sample_t                   d1;
	sample_t                   d2;
	sample_t                   d3;
	sample_t                   ca;
	logic signed [AUDIO_W:0]   p;
	logic signed [AUDIO_W:0]   a1;
	logic signed [AUDIO_W:0]   a3;
	logic signed [AUDIO_W:0]   a4;

	// other channel, sign extended
	assign p = {i_pre[AUDIO_W-1], i_pre};

	always_ff @(posedge clk) begin
		// take a sample only once two delayed copies agree
		d1 <= i_sample;
		d2 <= d1;
		d3 <= d2;
		if (d2 == d3)
			ca <= d2;

		// unsigned input is halved into the positive range
		a1 <= i_is_signed ? {ca[AUDIO_W-1], ca} : {2'b00, ca[AUDIO_W-1:1]};

		case (i_mix)
			2'd0:    a3 <= a1;
			2'd1:    a3 <= a1 - (a1 >>> 3) + (p >>> 2);
			2'd2:    a3 <= a1 - (a1 >>> 2) + (p >>> 1);
			default: a3 <= (a1 >>> 1) + p;
		endcase

		if (i_att[ATT_W-1])
			a4 <= '0;
		else
			a4 <= a3 >>> i_att[ATT_W-2:0];
	end

	always_ff @(posedge clk) begin
		if (resetd) begin
			o_pre    <= '0;
			o_sample <= '0;
		end else begin
			o_pre <= a1[AUDIO_W:1];
			// saturate to 16 bits
			if (a4[AUDIO_W] ^ a4[AUDIO_W-1])
				o_sample <= {a4[AUDIO_W], {(AUDIO_W-1){~a4[AUDIO_W]}}};
			else
				o_sample <= a4[AUDIO_W-1:0];
		end
	end

endmodule

// File: sync_polarity.sv
////////////////////////////////////////////////////////////////////////////
// sync polarity normaliser
// makes a sync of either polarity active high
////////////////////////////////////////////////////////////////////////////

module sync_polarity #(
	parameter int H_CNT_W = 16
) (
	input  logic clk,
	input  logic resetd,
	input  logic i_sync,
	output logic o_sync
);
	logic               s1;
	logic               s2;
	logic [H_CNT_W-1:0] cnt;
	logic [H_CNT_W-1:0] hi_len;
	logic [H_CNT_W-1:0] lo_len;
	logic               pol;

	assign o_sync = i_sync ^ pol;

	always_ff @(posedge clk) begin
		if (resetd) begin
			s1     <= 1'b0;
			s2     <= 1'b0;
			cnt    <= '0;
			hi_len <= '0;
			lo_len <= '0;
			pol    <= 1'b0;
		end else begin
			s1 <= i_sync;
			s2 <= s1;
			// run lengths ending at each edge
			if (s1 & ~s2)
				lo_len <= cnt;
			if (~s1 & s2)
				hi_len <= cnt;
			if (s1 != s2)
				cnt <= '0;
			else if (cnt != '1)
				cnt <= cnt + H_CNT_W'(1);
			// the longer level is the inactive one
			pol <= hi_len > lo_len;
		end
	end

endmodule

// File: csync_gen.sv
////////////////////////////////////////////////////////////////////////////
// composite sync generator
// hsync shifted by one line during vsync, xor vsync
////////////////////////////////////////////////////////////////////////////

module csync_gen #(
	parameter int H_CNT_W = 16
) (
	input  logic clk,
	input  logic resetd,
	input  logic i_hs,
	input  logic i_vs,
	input  logic i_csync_en,
	output logic o_hs_out,
	output logic o_csync
);
	logic               hs_d;
	logic               hs_edge;
	logic [H_CNT_W-1:0] h_cnt;
	logic [H_CNT_W-1:0] line_len;
	logic [H_CNT_W-1:0] hs_len;
	logic               cs_hs;
	logic               cs_vs;

	assign hs_edge  = hs_d ^ i_hs;
	assign o_csync  = cs_hs ^ cs_vs;
	assign o_hs_out = i_csync_en ? o_csync : i_hs;

	always_ff @(posedge clk) begin
		if (resetd) begin
			hs_d     <= 1'b0;
			h_cnt    <= '0;
			line_len <= '0;
			hs_len   <= '0;
			cs_hs    <= 1'b0;
			cs_vs    <= 1'b0;
		end else begin
			hs_d  <= i_hs;
			cs_vs <= i_vs;

			// h_cnt restarts at every hsync edge
			if (hs_edge) begin
				h_cnt <= '0;
				if (i_hs)
					line_len <= h_cnt - hs_len;
				else
					hs_len <= h_cnt;
			end else begin
				h_cnt <= h_cnt + H_CNT_W'(1);
			end

			// inside vsync the pulse lands one hsync width before the next line
			if (!i_vs)
				cs_hs <= i_hs;
			else if (h_cnt == line_len)
				cs_hs <= 1'b1;
			else if (hs_edge && i_hs)
				cs_hs <= 1'b0;
		end
	end

endmodule

// File: hps_top.sv
////////////////////////////////////////////////////////////////////////////
// board abstraction top, system clock side
// host commands, video window, audio mix, sync clean-up and LEDs
////////////////////////////////////////////////////////////////////////////

module hps_top #(
	parameter int H_CNT_W = 16
) (
	input  logic                 clk,
	input  logic                 resetd,
	input  logic                 i_io_sel,
	input  logic                 i_io_clk,
	input  hps_io_pkg::io_word_t i_io_din,
	input  logic                 i_hs_core,
	input  logic                 i_vs_core,
	input  hps_io_pkg::aspect_t  i_arx,
	input  hps_io_pkg::aspect_t  i_ary,
	input  hps_io_pkg::sample_t  i_audio_l,
	input  hps_io_pkg::sample_t  i_audio_r,
	input  logic                 i_audio_s,
	input  hps_io_pkg::mix_t     i_audio_mix,
	input  logic                 i_led_user,
	input  logic [1:0]           i_led_power,
	input  logic [1:0]           i_led_disk,
	output logic                 o_io_ack,
	output logic [7:0]           o_led,
	output hps_io_pkg::timing_t  o_hmin,
	output hps_io_pkg::timing_t  o_hmax,
	output hps_io_pkg::timing_t  o_vmin,
	output hps_io_pkg::timing_t  o_vmax,
	output hps_io_pkg::sample_t  o_audio_l,
	output hps_io_pkg::sample_t  o_audio_r,
	output logic                 o_hs,
	output logic                 o_vs,
	output logic                 o_csync
);
	import hps_io_pkg::*;

	timing_t          width;
	timing_t          height;
	timing_t          vset;
	logic [ATT_W-1:0] vol_att;
	logic             csync_en;
	logic             hs_norm;
	sample_t          pre_l;
	sample_t          pre_r;

	hps_cmd_ctrl u_ctrl (
		.clk(clk), .resetd(resetd),
		.i_io_sel(i_io_sel), .i_io_clk(i_io_clk), .i_io_din(i_io_din),
		.i_vs(o_vs),
		.i_led_user(i_led_user), .i_led_power(i_led_power), .i_led_disk(i_led_disk),
		.o_io_ack(o_io_ack),
		.o_width(width), .o_height(height), .o_vset(vset),
		.o_vol_att(vol_att), .o_csync_en(csync_en), .o_led(o_led)
	);

	video_window u_window (
		.clk(clk), .resetd(resetd),
		.i_width(width), .i_height(height), .i_vset(vset),
		.i_arx(i_arx), .i_ary(i_ary),
		.o_hmin(o_hmin), .o_hmax(o_hmax), .o_vmin(o_vmin), .o_vmax(o_vmax)
	);

	// left and right feed each other through o_pre
	audio_mixer u_mix_l (
		.clk(clk), .resetd(resetd), .i_att(vol_att), .i_mix(i_audio_mix),
		.i_is_signed(i_audio_s), .i_sample(i_audio_l), .i_pre(pre_r),
		.o_pre(pre_l), .o_sample(o_audio_l)
	);

	audio_mixer u_mix_r (
		.clk(clk), .resetd(resetd), .i_att(vol_att), .i_mix(i_audio_mix),
		.i_is_signed(i_audio_s), .i_sample(i_audio_r), .i_pre(pre_l),
		.o_pre(pre_r), .o_sample(o_audio_r)
	);

	sync_polarity #(.H_CNT_W(H_CNT_W)) u_pol_h (
		.clk(clk), .resetd(resetd), .i_sync(i_hs_core), .o_sync(hs_norm)
	);

	sync_polarity #(.H_CNT_W(H_CNT_W)) u_pol_v (
		.clk(clk), .resetd(resetd), .i_sync(i_vs_core), .o_sync(o_vs)
	);

	csync_gen #(.H_CNT_W(H_CNT_W)) u_csync (
		.clk(clk), .resetd(resetd), .i_hs(hs_norm), .i_vs(o_vs),
		.i_csync_en(csync_en), .o_hs_out(o_hs), .o_csync(o_csync)
	);

endmodule

// File: tb_hps_top.sv
////////////////////////////////////////////////////////////////////////////
// testbench for hps_top
// host command driver, sync source and reference models
////////////////////////////////////////////////////////////////////////////

module tb_hps_top;
	import hps_io_pkg::*;

	localparam int SEED        = 92993;
	localparam int LINE        = 32;
	localparam int HS_W        = 4;
	localparam int LINES       = 10;
	localparam int VS_LINES    = 2;
	localparam int FRAME       = LINE * LINES;
	localparam int ACK_TIMEOUT = 40;

	logic       clk;
	logic       resetd;
	logic       i_io_sel;
	logic       i_io_clk;
	io_word_t   i_io_din;
	logic       i_hs_core;
	logic       i_vs_core;
	aspect_t    i_arx;
	aspect_t    i_ary;
	sample_t    i_audio_l;
	sample_t    i_audio_r;
	logic       i_audio_s;
	mix_t       i_audio_mix;
	logic       i_led_user;
	logic [1:0] i_led_power;
	logic [1:0] i_led_disk;
	logic       o_io_ack;
	logic [7:0] o_led;
	timing_t    o_hmin;
	timing_t    o_hmax;
	timing_t    o_vmin;
	timing_t    o_vmax;
	sample_t    o_audio_l;
	sample_t    o_audio_r;
	logic       o_hs;
	logic       o_vs;
	logic       o_csync;
	logic       hs_inv;
	logic       vs_inv;
	string      test_name;

	hps_top #(.H_CNT_W(16)) uut (
		.clk(clk), .resetd(resetd),
		.i_io_sel(i_io_sel), .i_io_clk(i_io_clk), .i_io_din(i_io_din),
		.i_hs_core(i_hs_core), .i_vs_core(i_vs_core), .i_arx(i_arx), .i_ary(i_ary),
		.i_audio_l(i_audio_l), .i_audio_r(i_audio_r), .i_audio_s(i_audio_s),
		.i_audio_mix(i_audio_mix), .i_led_user(i_led_user),
		.i_led_power(i_led_power), .i_led_disk(i_led_disk),
		.o_io_ack(o_io_ack), .o_led(o_led),
		.o_hmin(o_hmin), .o_hmax(o_hmax), .o_vmin(o_vmin), .o_vmax(o_vmax),
		.o_audio_l(o_audio_l), .o_audio_r(o_audio_r),
		.o_hs(o_hs), .o_vs(o_vs), .o_csync(o_csync)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	/////////////////////////  checks  ///////////////////////////////////////

	task automatic abort_run();
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check_timing(input string what, input timing_t exp, input timing_t act);
		if (act !== exp) begin
			$display("Error: %s %s expected %0d actual %0d", test_name, what, exp, act);
			abort_run();
		end
	endtask

	task automatic check_sample(input string what, input sample_t exp, input sample_t act);
		if (act !== exp) begin
			$display("Error: %s %s expected %h actual %h", test_name, what, exp, act);
			abort_run();
		end
	endtask

	task automatic check_led(input string what, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("Error: %s %s expected %b actual %b", test_name, what, exp, act);
			abort_run();
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Error: %s %s expected %b actual %b", test_name, what, exp, act);
			abort_run();
		end
	endtask

	/////////////////////////  host port  ////////////////////////////////////

	task automatic wait_ack(input logic level);
		int t;
		t = 0;
		@(negedge clk);
		while (o_io_ack !== level) begin
			if (t == ACK_TIMEOUT) begin
				$display("%s: host ack did not reach %b in time", test_name, level);
				abort_run();
			end
			@(negedge clk);
			t++;
		end
	endtask

	task automatic send_word(input io_word_t w);
		@(posedge clk);
		i_io_din <= w;
		i_io_clk <= 1'b1;
		wait_ack(1'b1);
		@(posedge clk);
		i_io_clk <= 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic send_cmd(input hps_cmd_e op, input io_word_t data[$]);
		@(posedge clk);
		i_io_sel <= 1'b1;
		send_word({8'h00, op});
		foreach (data[i])
			send_word(data[i]);
		@(posedge clk);
		i_io_sel <= 1'b0;
		repeat (2) @(posedge clk);
	endtask

	// periodic sync with an active pulse at the start of each line and frame
	task automatic sync_source();
		int h_pos;
		int v_line;
		h_pos = 0;
		v_line = 0;
		i_hs_core <= 1'b1 ^ hs_inv;
		i_vs_core <= 1'b1 ^ vs_inv;
		forever begin
			@(posedge clk);
			if (h_pos == LINE - 1) begin
				h_pos = 0;
				v_line = (v_line == LINES - 1) ? 0 : v_line + 1;
			end else begin
				h_pos = h_pos + 1;
			end
			i_hs_core <= (h_pos < HS_W) ^ hs_inv;
			i_vs_core <= (v_line < VS_LINES) ^ vs_inv;
		end
	endtask

	/////////////////////////  models  ///////////////////////////////////////

	function automatic logic [7:0] led_model(input logic [7:0] mask, input logic [7:0] state,
		input logic user, input logic [1:0] power, input logic [1:0] disk);
		logic [7:0] core;
		core = 8'h00;
		core[4] = !power[1] || power[0];
		// disk lit by bit 0 in both modes
		core[2] = disk[0];
		core[0] = user;
		return (core & ~mask) | (state & mask);
	endfunction

	task automatic window_model(input int w, input int h, input int v, input int rx,
		input int ry, output timing_t hmin, output timing_t hmax, output timing_t vmin,
		output timing_t vmax);
		int tw, th, vw, vh;
		if (rx == 0 || ry == 0) begin
			vw = w;
			vh = h;
		end else begin
			tw = ((v != 0) ? v : h) * rx / ry;
			th = w * ry / rx;
			vw = (v == 0 && tw > w) ? w : tw;
			vh = (v != 0) ? v : ((th > h) ? h : th);
		end
		hmin = timing_t'((w - vw) / 2);
		hmax = timing_t'((w - vw) / 2 + vw - 1);
		vmin = timing_t'((h - vh) / 2);
		vmax = timing_t'((h - vh) / 2 + vh - 1);
	endtask

	function automatic int widen_sample(input sample_t s, input logic sgn);
		if (sgn)
			return int'($signed(s));
		return int'(s) / 2;
	endfunction

	function automatic sample_t mix_model(input int a, input int p, input mix_t mode,
		input logic [4:0] att);
		int m;
		case (mode)
			2'd0:    m = a;
			2'd1:    m = a - (a >>> 3) + (p >>> 2);
			2'd2:    m = a - (a >>> 2) + (p >>> 1);
			default: m = (a >>> 1) + p;
		endcase
		m = att[4] ? 0 : (m >>> att[3:0]);
		if (m > 32767)
			m = 32767;
		if (m < -32768)
			m = -32768;
		return sample_t'(m);
	endfunction

	/////////////////////////  tests  ////////////////////////////////////////

	task automatic led_test();
		logic [7:0] mask;
		logic [7:0] state;
		io_word_t   words[$];
		test_name = "led";
		for (int n = 0; n < 16; n++) begin
			mask = 8'($urandom);
			state = 8'($urandom);
			words.delete();
			words.push_back({mask, state});
			send_cmd(CMD_LED, words);
			for (int k = 0; k < 4; k++) begin
				@(posedge clk);
				i_led_user <= 1'($urandom);
				i_led_power <= 2'($urandom);
				i_led_disk <= 2'($urandom);
				@(negedge clk);
				check_led("o_led", led_model(mask, state, i_led_user, i_led_power,
					i_led_disk), o_led);
			end
		end
	endtask

	task automatic drive_aspect(input int rx, input int ry);
		@(posedge clk);
		i_arx <= aspect_t'(rx);
		i_ary <= aspect_t'(ry);
	endtask

	task automatic window_test();
		int       w, h, v, rx, ry;
		timing_t  hmin, hmax, vmin, vmax;
		io_word_t words[$];
		test_name = "window";
		for (int n = 0; n < 12; n++) begin
			w = $urandom_range(640, 1920);
			h = $urandom_range(360, 1080);
			v = ($urandom_range(0, 2) == 0) ? $urandom_range(h / 4, h / 2) : 0;
			ry = $urandom_range(1, 15);
			// fixed height keeps the width inside the frame
			rx = (v != 0) ? $urandom_range(1, ry) : $urandom_range(1, 15);
			if ($urandom_range(0, 4) == 0)
				rx = 0;
			else if ($urandom_range(0, 4) == 0)
				ry = 0;
			drive_aspect(0, 0);
			words.delete();
			words.push_back(io_word_t'(w));
			repeat (3) words.push_back(io_word_t'(0));
			words.push_back(io_word_t'(h));
			send_cmd(CMD_TIMING, words);
			words.delete();
			words.push_back(io_word_t'(v));
			send_cmd(CMD_VSET, words);
			drive_aspect(rx, ry);
			repeat (20) @(posedge clk);
			@(negedge clk);
			window_model(w, h, v, rx, ry, hmin, hmax, vmin, vmax);
			check_timing("o_hmin", hmin, o_hmin);
			check_timing("o_hmax", hmax, o_hmax);
			check_timing("o_vmin", vmin, o_vmin);
			check_timing("o_vmax", vmax, o_vmax);
		end
	endtask

	task automatic audio_test();
		sample_t    l, r;
		mix_t       mode;
		logic       sgn;
		logic [4:0] att;
		int         al, ar;
		io_word_t   words[$];
		test_name = "audio";
		for (int n = 0; n < 24; n++) begin
			l = sample_t'($urandom);
			r = sample_t'($urandom);
			mode = mix_t'($urandom);
			sgn = 1'($urandom);
			att = ($urandom_range(0, 3) == 0) ? 5'($urandom_range(16, 31)) :
				5'($urandom_range(0, 6));
			words.delete();
			words.push_back(io_word_t'(att));
			send_cmd(CMD_VOL, words);
			@(posedge clk);
			i_audio_l <= l;
			i_audio_r <= r;
			i_audio_mix <= mode;
			i_audio_s <= sgn;
			repeat (12) @(posedge clk);
			@(negedge clk);
			al = widen_sample(l, sgn);
			ar = widen_sample(r, sgn);
			check_sample("o_audio_l", mix_model(al, ar >>> 1, mode, att), o_audio_l);
			check_sample("o_audio_r", mix_model(ar, al >>> 1, mode, att), o_audio_r);
		end
	endtask

	task automatic check_frames(input logic csync_on);
		logic hs_exp, vs_exp, hs_prev, vs_prev;
		@(negedge clk);
		hs_prev = i_hs_core ^ hs_inv;
		vs_prev = i_vs_core ^ vs_inv;
		repeat (2 * FRAME) begin
			@(negedge clk);
			hs_exp = i_hs_core ^ hs_inv;
			vs_exp = i_vs_core ^ vs_inv;
			check_bit("o_vs", vs_exp, o_vs);
			if (!vs_prev && !vs_exp)
				check_bit("o_csync", hs_prev, o_csync);
			if (!csync_on)
				check_bit("o_hs", hs_exp, o_hs);
			else if (!vs_prev && !vs_exp)
				check_bit("o_hs csync", hs_prev, o_hs);
			hs_prev = hs_exp;
			vs_prev = vs_exp;
		end
	endtask

	task automatic sync_test();
		io_word_t words[$];
		test_name = "sync";
		repeat (3 * FRAME) @(posedge clk);
		words.push_back(io_word_t'(0));
		send_cmd(CMD_CFG, words);
		check_frames(1'b0);
		words[0] = io_word_t'(8);
		send_cmd(CMD_CFG, words);
		check_frames(1'b1);
		words[0] = io_word_t'(0);
		send_cmd(CMD_CFG, words);
	endtask

	task automatic wait_vs_rise();
		int   t;
		logic prev;
		t = 0;
		@(negedge clk);
		prev = o_vs;
		@(negedge clk);
		while (prev || !o_vs) begin
			if (t == 2 * FRAME) begin
				$display("%s: no rising edge on o_vs", test_name);
				abort_run();
			end
			prev = o_vs;
			@(negedge clk);
			t++;
		end
	endtask

	task automatic vs_wait_test();
		int   t;
		logic vs_prev;
		logic rise_seen;
		test_name = "vs_wait";
		wait_vs_rise();
		@(posedge clk);
		i_io_sel <= 1'b1;
		send_word({8'h00, CMD_VS_WAIT});
		@(posedge clk);
		i_io_din <= io_word_t'(1);
		i_io_clk <= 1'b1;
		t = 0;
		rise_seen = 1'b0;
		@(negedge clk);
		vs_prev = o_vs;
		while (o_io_ack !== 1'b1) begin
			if ((!rise_seen && t == 2 * FRAME) || (rise_seen && t == ACK_TIMEOUT)) begin
				$display("%s: ack not released after vertical sync", test_name);
				abort_run();
			end
			@(negedge clk);
			t++;
			if (!rise_seen && !vs_prev && o_vs) begin
				rise_seen = 1'b1;
				t = 0;
			end
			vs_prev = o_vs;
		end
		if (!rise_seen) begin
			$display("%s: ack rose before the vertical sync edge", test_name);
			abort_run();
		end
		@(posedge clk);
		i_io_clk <= 1'b0;
		wait_ack(1'b0);
		@(posedge clk);
		i_io_sel <= 1'b0;
		repeat (2) @(posedge clk);
	endtask

	initial begin
		resetd <= 1'b1;
		i_io_sel <= 1'b0;
		i_io_clk <= 1'b0;
		i_io_din <= '0;
		i_arx <= '0;
		i_ary <= '0;
		i_audio_l <= '0;
		i_audio_r <= '0;
		i_audio_s <= 1'b0;
		i_audio_mix <= '0;
		i_led_user <= 1'b0;
		i_led_power <= '0;
		i_led_disk <= '0;
		test_name = "reset";
		void'($urandom(SEED));
		hs_inv = 1'($urandom);
		vs_inv = 1'($urandom);
		fork
			sync_source();
		join_none
		repeat (5) @(posedge clk);
		resetd <= 1'b0;
		led_test();
		window_test();
		audio_test();
		sync_test();
		vs_wait_test();
		$display("Testbench passed");
		$finish;
	end

endmodule

// File: all.f
hps_io_pkg.sv
hps_cmd_ctrl.sv
video_window.sv
audio_mixer.sv
sync_polarity.sv
csync_gen.sv
hps_top.sv
tb_hps_top.sv

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module tb_hps_top -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Testbench passed" "$LOG"; then
	echo "result: pass"
	exit 0
else
	echo "result: fail"
	exit 1
fi
